//--- hdl/rob_defs.svh
/*
 * Sizing constants for the reorder buffer
 * Include wherever depth, ID width, port count or result width is needed
 */

`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Number of in-flight transactions
`define ROB_DEPTH 8
// Transaction ID width, enough to address ROB_DEPTH entries
`define ROB_ID_W 3
// Retire ports towards the execution stages
`define RETIRE_PORTS 4
// Result word carried from retire to commit
`define ROB_DATA_W 16

`endif

//--- hdl/rob_pkg.sv
/*
 * Shared types of the reorder buffer
 * Import with a wildcard in the module header of each user
 */

`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

    // One transaction ID, wraps modulo ROB_DEPTH
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // One result word from a retire port
    typedef logic [`ROB_DATA_W-1:0] rob_data_t;

    // Entry held in each retire-port memory
    typedef struct packed {
        logic      completed;
        rob_data_t data;
    } rob_entry_t;

    // Record handed to the commit stage
    typedef struct packed {
        rob_id_t   id;
        rob_data_t data;
    } rob_commit_t;

endpackage

`default_nettype wire

//--- hdl/stage_register.sv
/*
 * One-deep valid/ready register for any payload type
 * Used on the issue response and on the commit path
 */

`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module stage_register #(
    parameter type payload_t = logic [`ROB_DATA_W-1:0]
) (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire logic in_valid_i,
    output logic      in_ready_o,
    input  payload_t  in_data_i,
    output logic      out_valid_o,
    output payload_t  out_data_o,
    input  wire logic out_ready_i
);

    payload_t data_q;

    // Accept when empty or when the held payload leaves this cycle
    assign in_ready_o = ~out_valid_o | out_ready_i;

    // Valid bit tracks occupancy
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    // Payload loads only on an input transfer
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_data_o = data_q;

endmodule

`default_nettype wire

//--- hdl/id_fifo.sv
/*
 * Circular FIFO of allocated transaction IDs
 * Head is the eldest in-flight ID; push and pop may share a cycle
 */

`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module id_fifo import rob_pkg::*; (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire logic push_i,
    input  rob_id_t   push_id_i,
    input  wire logic pop_i,
    output rob_id_t   head_id_o,
    output logic      full_o,
    output logic      empty_o
);

    // Last slot index, pointers wrap after it
    localparam rob_id_t LAST_SLOT = rob_id_t'(`ROB_DEPTH - 1);

    rob_id_t              slots_q [`ROB_DEPTH];
    rob_id_t              rd_ptr_q;
    rob_id_t              wr_ptr_q;
    logic [`ROB_ID_W:0]   count_q;
    logic                 push_ok;
    logic                 pop_ok;

    // Occupancy flags
    assign full_o  = (count_q == (`ROB_ID_W + 1)'(`ROB_DEPTH));
    assign empty_o = (count_q == '0);

    // Ignore push when full and pop when empty
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    // Pointers and count
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Slot storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            slots_q[wr_ptr_q] <= push_id_i;
        end
    end

    assign head_id_o = slots_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- hdl/rob_memory.sv
/*
 * Entry store for one retire port, indexed by transaction ID
 * Written by its retire port, read and cleared at the FIFO head
 */

`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module rob_memory import rob_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  wr_valid_i,
    input  rob_id_t    wr_id_i,
    input  rob_data_t  wr_data_i,
    input  rob_id_t    head_id_i,
    input  wire logic  clear_i,
    output rob_entry_t head_entry_o
);

    rob_entry_t entries_q [`ROB_DEPTH];
    rob_entry_t wr_entry;

    // A retire write always marks the entry completed
    assign wr_entry = '{completed: 1'b1, data: wr_data_i};

    //////////////////////////////////////////
    // Write and clear
    //////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries_q[i] <= '0;
            end
        end else begin
            // Committed head entry returns to empty
            if (clear_i) begin
                entries_q[head_id_i] <= '0;
            end
            // Different entries both update
            // on the same entry the write is the later assignment
            if (wr_valid_i) begin
                entries_q[wr_id_i] <= wr_entry;
            end
        end
    end

    //////////////////////////////////////////
    // Head read
    //////////////////////////////////////////

    // Combinational, follows the FIFO head directly
    assign head_entry_o = entries_q[head_id_i];

endmodule

`default_nettype wire

//--- hdl/retire_stage.sv
/*
 * Reorder buffer top level
 * Hands out IDs in order, collects results on the retire ports
 * and commits the eldest completed transaction in allocation order
 */

`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module retire_stage import rob_pkg::*; (
    input  wire logic clk_i,
    input  wire logic rst_ni,

    // Issue request and ID response
    input  wire logic issue_valid_i,
    output logic      issue_ready_o,
    output logic      issue_id_valid_o,
    output rob_id_t   issue_id_o,
    input  wire logic issue_id_ready_i,

    // Retire ports, always accepted
    input  wire logic retire_valid_i [`RETIRE_PORTS],
    input  rob_id_t   retire_id_i    [`RETIRE_PORTS],
    input  rob_data_t retire_data_i  [`RETIRE_PORTS],

    // Commit port
    output logic      commit_valid_o,
    output rob_id_t   commit_id_o,
    output rob_data_t commit_data_o,
    input  wire logic commit_ready_i
);

    localparam rob_id_t LAST_ID = rob_id_t'(`ROB_DEPTH - 1);

    // Allocation
    rob_id_t     next_id_q;
    logic        issue_in_ready;
    logic        alloc;

    // FIFO
    logic        fifo_full;
    logic        fifo_empty;
    rob_id_t     head_id;

    // Memories and selection
    rob_entry_t  head_entry [`RETIRE_PORTS];
    logic        sel_found;
    rob_data_t   sel_data;

    // Commit
    logic        pop;
    logic        commit_in_ready;
    rob_commit_t commit_rec;
    rob_commit_t commit_out;

    ////////////////////////////////////////
    // ID allocation
    ////////////////////////////////////////

    // Room in the FIFO and in the issue register
    assign issue_ready_o = ~fifo_full & issue_in_ready;
    assign alloc         = issue_valid_i & issue_ready_o;

    // Next ID wraps modulo depth
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            next_id_q <= '0;
        end else if (alloc) begin
            next_id_q <= (next_id_q == LAST_ID) ? '0 : next_id_q + 1'b1;
        end
    end

    // Issue response register, loads exactly on alloc
    stage_register #(.payload_t(rob_id_t)) issue_reg0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (issue_valid_i & ~fifo_full),
        .in_ready_o  (issue_in_ready),
        .in_data_i   (next_id_q),
        .out_valid_o (issue_id_valid_o),
        .out_data_o  (issue_id_o),
        .out_ready_i (issue_id_ready_i)
    );

    // In-flight IDs in allocation order
    id_fifo id_fifo0 (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push_i    (alloc),
        .push_id_i (next_id_q),
        .pop_i     (pop),
        .head_id_o (head_id),
        .full_o    (fifo_full),
        .empty_o   (fifo_empty)
    );

    // One entry store per retire port, all read at the head ID
    for (genvar p = 0; p < `RETIRE_PORTS; p++) begin : gen_mem
        rob_memory rob_memory0 (
            .clk_i        (clk_i),
            .rst_ni       (rst_ni),
            .wr_valid_i   (retire_valid_i[p]),
            .wr_id_i      (retire_id_i[p]),
            .wr_data_i    (retire_data_i[p]),
            .head_id_i    (head_id),
            .clear_i      (pop),
            .head_entry_o (head_entry[p])
        );
    end

    ////////////////////////////////////////
    // Eldest-entry selector
    ////////////////////////////////////////

    // Scan upwards so the highest completed port wins
    always_comb begin
        sel_found = 1'b0;
        sel_data  = '0;
        for (int p = 0; p < `RETIRE_PORTS; p++) begin
            if (head_entry[p].completed) begin
                sel_found = 1'b1;
                sel_data  = head_entry[p].data;
            end
        end
    end

    ////////////////////////////////////////
    // Pop control
    ////////////////////////////////////////

    // Head completed on some port and commit register has room
    assign pop        = ~fifo_empty & sel_found & commit_in_ready;
    assign commit_rec = '{id: head_id, data: sel_data};

    // Commit register, transfers exactly on pop
    stage_register #(.payload_t(rob_commit_t)) commit_reg0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (~fifo_empty & sel_found),
        .in_ready_o  (commit_in_ready),
        .in_data_i   (commit_rec),
        .out_valid_o (commit_valid_o),
        .out_data_o  (commit_out),
        .out_ready_i (commit_ready_i)
    );

    // Split the record onto the commit ports
    assign commit_id_o   = commit_out.id;
    assign commit_data_o = commit_out.data;

endmodule

`default_nettype wire

//--- tests/retire_stage_chk.sv
/*
 * Handshake and retire-target assertions, bound into the reorder buffer top level
 */

`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module retire_stage_chk import rob_pkg::*; (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic issue_id_valid_o,
    input rob_id_t   issue_id_o,
    input wire logic issue_id_ready_i,
    input wire logic commit_valid_o,
    input rob_id_t   commit_id_o,
    input rob_data_t commit_data_o,
    input wire logic commit_ready_i,
    input wire logic alloc,
    input rob_id_t   next_id_q,
    input wire logic pop,
    input rob_id_t   head_id,
    input wire logic retire_valid_i [`RETIRE_PORTS],
    input rob_id_t   retire_id_i    [`RETIRE_PORTS]
);

    // One bit per ID, set on allocation and cleared on pop
    logic [`ROB_DEPTH-1:0] in_flight_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            in_flight_q <= '0;
        end else begin
            if (pop) begin
                in_flight_q[head_id] <= 1'b0;
            end
            if (alloc) begin
                in_flight_q[next_id_q] <= 1'b1;
            end
        end
    end

    // Issue response holds until taken
    a_issue_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_id_valid_o && !issue_id_ready_i |=> issue_id_valid_o && $stable(issue_id_o))
        else $error("issue response dropped or changed while stalled");

    // Commit record holds until taken
    a_commit_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_valid_o && !commit_ready_i |=>
        commit_valid_o && $stable(commit_id_o) && $stable(commit_data_o))
        else $error("commit output dropped or changed while stalled");

    // Retire writes only hit IDs in flight
    for (genvar p = 0; p < `RETIRE_PORTS; p++) begin : gen_tgt
        a_retire_tgt: assert property (@(posedge clk_i) disable iff (!rst_ni)
            retire_valid_i[p] |-> in_flight_q[retire_id_i[p]])
            else $error("retire write to an ID that is not in flight");
    end

endmodule

bind retire_stage retire_stage_chk chk0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_id_valid_o (issue_id_valid_o),
    .issue_id_o       (issue_id_o),
    .issue_id_ready_i (issue_id_ready_i),
    .commit_valid_o   (commit_valid_o),
    .commit_id_o      (commit_id_o),
    .commit_data_o    (commit_data_o),
    .commit_ready_i   (commit_ready_i),
    .alloc            (alloc),
    .next_id_q        (next_id_q),
    .pop              (pop),
    .head_id          (head_id),
    .retire_valid_i   (retire_valid_i),
    .retire_id_i      (retire_id_i)
);

`default_nettype wire

//--- tests/retire_stage_monitor.sv
/*
 * Watches the reorder buffer ports, predicts issued IDs and commits
 * The testbench calls start_test, finish_test and report by hierarchy
 */

`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module retire_stage_monitor import rob_pkg::*; (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic issue_valid_i,
    input wire logic issue_ready_o,
    input wire logic issue_id_valid_o,
    input rob_id_t   issue_id_o,
    input wire logic issue_id_ready_i,
    input wire logic retire_valid_i [`RETIRE_PORTS],
    input rob_id_t   retire_id_i    [`RETIRE_PORTS],
    input rob_data_t retire_data_i  [`RETIRE_PORTS],
    input wire logic commit_valid_o,
    input rob_id_t   commit_id_o,
    input rob_data_t commit_data_o,
    input wire logic commit_ready_i
);

    rob_id_t   alloc_id;
    rob_id_t   resp_q [$];
    rob_id_t   fifo_q [$];
    rob_id_t   commit_q [$];
    rob_data_t data_by_id [`ROB_DEPTH];
    logic      done_by_id [`ROB_DEPTH];
    rob_id_t   exp_id;
    rob_id_t   popped_id;
    logic      ready_exp;
    logic      can_accept;
    logic      pop_exp;
    logic      creg_valid = 1'b0;
    logic      hold_valid = 1'b0;
    rob_id_t   hold_id;
    rob_data_t hold_data;
    string     test_name = "reset";
    int        reset_cycles = 0;
    int        test_errors = 0;
    int        error_count = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        commit_count = 0;

    task automatic check_value(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("[FAIL] %s: %s expected %0d, actual %0d", test_name, what, exp, act);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("Error in test %s: %s", test_name, msg);
        test_errors++;
        error_count++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d failed, %0d errors, %0d commits",
                 tests_run, tests_failed, error_count, commit_count);
    endtask

    ////////////////////////////////////////
    // Per-edge prediction and compare
    ////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            // From the second reset edge on both valids must be low
            if (reset_cycles > 0 && (issue_id_valid_o !== 1'b0 || commit_valid_o !== 1'b0)) begin
                report_problem("a valid output is high during reset");
            end
            reset_cycles++;
            alloc_id   = '0;
            hold_valid = 1'b0;
            creg_valid = 1'b0;
            resp_q.delete();
            fifo_q.delete();
            commit_q.delete();
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                done_by_id[i] = 1'b0;
            end
        end else begin
            // Issue register holds the one response not yet taken
            ready_exp = (fifo_q.size() < `ROB_DEPTH) && (resp_q.size() == 0 || issue_id_ready_i);
            check_value("issue_ready_o", int'(ready_exp), int'(issue_ready_o));
            check_value("issue_id_valid_o", int'(resp_q.size() != 0), int'(issue_id_valid_o));
            check_value("commit_valid_o", int'(creg_valid), int'(commit_valid_o));
            if (hold_valid) begin
                if (!commit_valid_o || commit_id_o != hold_id || commit_data_o != hold_data) begin
                    report_problem("commit output changed while commit_ready_i was low");
                end
            end
            if (resp_q.size() != 0 && issue_id_ready_i) begin
                exp_id = resp_q.pop_front();
                check_value("issue_id_o", exp_id, issue_id_o);
            end
            // Eldest ID leaves once completed and the commit register has room
            can_accept = !creg_valid || commit_ready_i;
            pop_exp    = 1'b0;
            if (fifo_q.size() != 0 && can_accept) begin
                pop_exp = done_by_id[fifo_q[0]];
            end
            if (can_accept) begin
                creg_valid = pop_exp;
            end
            if (pop_exp) begin
                popped_id             = fifo_q.pop_front();
                done_by_id[popped_id] = 1'b0;
            end
            // Allocation order is the expected commit order
            if (issue_valid_i && ready_exp) begin
                resp_q.push_back(alloc_id);
                fifo_q.push_back(alloc_id);
                commit_q.push_back(alloc_id);
                alloc_id = alloc_id + 1'b1;
            end
            for (int p = 0; p < `RETIRE_PORTS; p++) begin
                if (retire_valid_i[p]) begin
                    data_by_id[retire_id_i[p]] = retire_data_i[p];
                    done_by_id[retire_id_i[p]] = 1'b1;
                end
            end
            if (commit_valid_o && commit_ready_i) begin
                if (commit_q.size() == 0) begin
                    report_problem("commit with no ID in flight");
                end else begin
                    exp_id = commit_q.pop_front();
                    check_value("commit_id_o", exp_id, commit_id_o);
                    check_value("commit_data_o", data_by_id[exp_id], commit_data_o);
                end
                commit_count++;
            end
            hold_valid = commit_valid_o && !commit_ready_i;
            hold_id    = commit_id_o;
            hold_data  = commit_data_o;
        end
    end

endmodule

`default_nettype wire

//--- tests/retire_stage_tb.sv
/*
 * Reorder buffer testbench top
 * Applies a table of issue, retire and stall patterns; the monitor does the compare
 */

`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module retire_stage_tb import rob_pkg::*; ;

    localparam int NFIXED     = 6;
    localparam int NROWS      = 30;
    localparam int ROW_CYCLES = 120;

    logic      clk_i = 1'b0;
    logic      rst_ni;
    logic      issue_valid_i;
    logic      issue_ready_o;
    logic      issue_id_valid_o;
    rob_id_t   issue_id_o;
    logic      issue_id_ready_i;
    logic      retire_valid_i [`RETIRE_PORTS];
    rob_id_t   retire_id_i    [`RETIRE_PORTS];
    rob_data_t retire_data_i  [`RETIRE_PORTS];
    logic      commit_valid_o;
    rob_id_t   commit_id_o;
    rob_data_t commit_data_o;
    logic      commit_ready_i;

    // Stimulus table, slot order and ports packed one nibble per slot
    string       row_name   [NROWS];
    int          row_n      [NROWS];
    logic [31:0] row_order  [NROWS];
    logic [31:0] row_port   [NROWS];
    logic [7:0]  row_cstall [NROWS];
    logic [7:0]  row_istall [NROWS];

    integer  seed = 32'hfd998055;
    int      cyc;
    int      row;
    rob_id_t base_id;

    retire_stage dut0 (.*);
    retire_stage_monitor mon0 (.*);

    always #50 clk_i = ~clk_i;

    task automatic add_row(input int idx, input string name, input int n,
                           input logic [31:0] order, input logic [31:0] port,
                           input logic [7:0] cs, input logic [7:0] is);
        row_name[idx]   = name;
        row_n[idx]      = n;
        row_order[idx]  = order;
        row_port[idx]   = port;
        row_cstall[idx] = cs;
        row_istall[idx] = is;
    endtask

    // Random rows use a shuffled slot order
    task automatic add_random_rows();
        int          perm [8];
        int          j;
        int          tmp;
        int          n;
        logic [31:0] order;
        logic [31:0] port;
        for (int r = NFIXED; r < NROWS; r++) begin
            n = 1 + ($unsigned($random(seed)) % `ROB_DEPTH);
            for (int i = 0; i < 8; i++) perm[i] = i;
            for (int i = n - 1; i > 0; i--) begin
                j       = $unsigned($random(seed)) % (i + 1);
                tmp     = perm[i];
                perm[i] = perm[j];
                perm[j] = tmp;
            end
            order = '0;
            port  = '0;
            for (int i = 0; i < n; i++) begin
                order[4*i +: 4] = 4'(perm[i]);
                port[4*i +: 4]  = 4'($unsigned($random(seed)) % `RETIRE_PORTS);
            end
            add_row(r, $sformatf("random_%0d", r - NFIXED), n, order, port,
                    8'($random(seed)) & 8'h77, 8'($random(seed)) & 8'h55);
        end
    endtask

    // Advance one clock, then drive the stall patterns
    task automatic step();
        @(posedge clk_i);
        #10;
        cyc++;
        commit_ready_i   = ~row_cstall[row][cyc % 8];
        issue_id_ready_i = ~row_istall[row][cyc % 8];
    endtask

    task automatic run_row(input int r);
        int issued;
        int target;
        int slot;
        int port;
        mon0.start_test(row_name[r]);
        target        = mon0.commit_count + row_n[r];
        issued        = 0;
        issue_valid_i = 1'b1;
        // Request held high until every allocation is accepted
        while (issued < row_n[r]) begin
            #1;
            if (issue_ready_o) issued++;
            step();
        end
        issue_valid_i = 1'b0;
        for (int s = 0; s < row_n[r]; s++) begin
            slot                 = row_order[r][4*s +: 4];
            port                 = row_port[r][4*s +: 4];
            retire_valid_i[port] = 1'b1;
            retire_id_i[port]    = rob_id_t'(base_id + slot);
            retire_data_i[port]  = rob_data_t'($random(seed));
            step();
            retire_valid_i[port] = 1'b0;
        end
        base_id = rob_id_t'(base_id + row_n[r]);
        while (mon0.commit_count < target || issue_id_valid_o) step();
        mon0.finish_test();
    endtask

    initial begin
        rst_ni           = 1'b0;
        issue_valid_i    = 1'b0;
        issue_id_ready_i = 1'b1;
        commit_ready_i   = 1'b1;
        for (int p = 0; p < `RETIRE_PORTS; p++) begin
            retire_valid_i[p] = 1'b0;
            retire_id_i[p]    = '0;
            retire_data_i[p]  = '0;
        end
        add_row(0, "in_order",     4, 32'h76543210, 32'h00000000, 8'h00, 8'h00);
        add_row(1, "reverse_full", 8, 32'h01234567, 32'h32103210, 8'h00, 8'h00);
        add_row(2, "mixed_ports",  6, 32'h00241503, 32'h00130123, 8'h00, 8'h00);
        add_row(3, "commit_stall", 5, 32'h00001234, 32'h00032211, 8'h7e, 8'h00);
        add_row(4, "issue_stall",  7, 32'h03241506, 32'h00321032, 8'h00, 8'haa);
        add_row(5, "both_stall",   8, 32'h35170624, 32'h12301230, 8'h3c, 8'h66);
        add_random_rows();
        cyc     = 0;
        row     = 0;
        base_id = '0;
        repeat (3) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        for (row = 0; row < NROWS; row++) begin
            run_row(row);
        end
        mon0.report();
        if (mon0.error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the row count
    initial begin
        #((NROWS * ROW_CYCLES + 50) * 100);
        $display("Watchdog timeout, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/rob_pkg.sv
hdl/stage_register.sv
hdl/id_fifo.sv
hdl/rob_memory.sv
hdl/retire_stage.sv
tests/retire_stage_chk.sv
tests/retire_stage_monitor.sv
tests/retire_stage_tb.sv

//--- Makefile
# Reorder buffer simulation with Verilator

TOP = retire_stage_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Ihdl -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Ihdl -f all.f --top-module $(TOP)
	verilator --lint-only -Ihdl hdl/rob_pkg.sv hdl/stage_register.sv hdl/id_fifo.sv \
		hdl/rob_memory.sv hdl/retire_stage.sv --top-module retire_stage

clean:
	rm -rf obj_dir sim.log
